//--- all.f
+incdir+include
logic/nic_pkg.sv
logic/nic_ifs.sv
logic/timestamp_counter.sv
logic/rx_slot_port.sv
logic/host_regs.sv
logic/nic_rx_top.sv
test/clock_gen.sv
test/tb_nic_rx.sv

//--- run.sh
#!/bin/sh
# compile the testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_nic_rx -f all.f --Mdir obj_dir -o tb_nic_rx_sim

if ! ./obj_dir/tb_nic_rx_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulator exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0

//--- test/tb_nic_rx.sv
`default_nettype none

`include "nic_settings.svh"

module tb_nic_rx;

  localparam int ACK_LIMIT  = 16;
  localparam int POLL_LIMIT = 64;
  localparam logic [15:0] CNT3_PAT = 16'hc3a5;
  localparam logic [15:0] CNT2_PAT = 16'h1e2d;

  logic                       clk_125;
  logic                       core_rst_n;
  logic                       bus_cyc;
  logic                       bus_stb;
  logic                       bus_we;
  logic [1:0]                 bus_sel;
  logic [15:0]                bus_adr;
  logic [15:0]                bus_wdat;
  logic [15:0]                bus_rdat;
  logic                       bus_ack;
  logic [`NUM_PORTS-1:0]      rx_dv;
  logic [`NUM_PORTS-1:0][7:0] rxd;
  logic                       irq;

  // bytes of the frame each slot should hold
  logic [7:0]  sent [`NUM_PORTS][2048];
  int          sent_len [`NUM_PORTS];

  logic [15:0] got_q [$];
  logic [15:0] exp_q [$];
  string       what_q [$];
  int          check_count;
  int          mismatch_count;
  int          error_count;
  int          timeout_count;

  clock_gen #(.PERIOD(4), .RST_CYCLES(4)) u_clk (
    .clk_o   (clk_125),
    .rst_n_o (core_rst_n)
  );

  nic_rx_top u_dut (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .bus_cyc_i    (bus_cyc),
    .bus_stb_i    (bus_stb),
    .bus_we_i     (bus_we),
    .bus_sel_i    (bus_sel),
    .bus_adr_i    (bus_adr),
    .bus_dat_i    (bus_wdat),
    .bus_dat_o    (bus_rdat),
    .bus_ack_o    (bus_ack),
    .gmii_rx_dv_i (rx_dv),
    .gmii_rxd_i   (rxd),
    .irq_o        (irq)
  );

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // lower target byte travels on dat[15:8]
  function automatic logic [15:0] bus_lanes(input logic [15:0] v);
    return {v[7:0], v[15:8]};
  endfunction

  function automatic logic [31:0] expected_word(input int p, input int w);
    logic [31:0] word;
    word = '0;
    for (int b = 0; b < 4; b++) begin
      if (4 * w + b < sent_len[p]) begin
        word[b*8 +: 8] = sent[p][4*w + b];
      end
    end
    return word;
  endfunction

  function automatic logic [15:0] expected_half(input int p, input int w, input int h);
    logic [31:0] word;
    word = expected_word(p, w);
    return (h != 0) ? word[31:16] : word[15:0];
  endfunction

  function automatic logic [15:0] expected_len(input int p);
    return 16'((sent_len[p] > 2047) ? 2047 : sent_len[p]);
  endfunction

  function automatic logic [15:0] reg_addr(input int idx);
    return 16'(idx << 1);
  endfunction

  function automatic logic [15:0] meta_addr(input int p, input int idx);
    return 16'(((`REGION_PORT0 + p) << 13) | (idx << 1));
  endfunction

  function automatic logic [15:0] mem_addr(input int p, input int w, input int h);
    return 16'(((`REGION_PORT0 + p) << 13) | (1 << 12) | (w << 2) | (h << 1));
  endfunction

  // ----------------------------------------------------------------------
  // bus and GMII drivers
  // ----------------------------------------------------------------------
  task automatic bus_xfer(input logic we, input logic [1:0] sel, input logic [15:0] adr,
                          input logic [15:0] wdat, input int exp_lat,
                          output logic [15:0] rdat);
    int  lat;
    bit  got_ack;
    @(posedge clk_125);
    #1;
    bus_cyc  = 1'b1;
    bus_stb  = 1'b1;
    bus_we   = we;
    bus_sel  = sel;
    bus_adr  = adr;
    bus_wdat = wdat;
    lat      = 0;
    got_ack  = 1'b0;
    rdat     = '0;
    while (!got_ack && lat < ACK_LIMIT) begin
      @(negedge clk_125);
      if (bus_ack) begin
        got_ack = 1'b1;
        rdat    = bus_rdat;
      end else begin
        lat++;
      end
    end
    if (!got_ack) begin
      timeout_count++;
      $display("timeout: no bus ack for address %h at time %0t", adr, $time);
    end else begin
      assert (lat == exp_lat) else begin
        error_count++;
        $display("[FAIL] t=%0t ack for address %h after %0d cycles, expected %0d",
                 $time, adr, lat, exp_lat);
      end
    end
    @(posedge clk_125);
    #1;
    bus_cyc = 1'b0;
    bus_stb = 1'b0;
    bus_we  = 1'b0;
  endtask

  task automatic read_expect(input logic [15:0] adr, input logic [15:0] exp,
                             input int exp_lat, input string what);
    logic [15:0] rdat;
    bus_xfer(1'b0, 2'b11, adr, '0, exp_lat, rdat);
    got_q.push_back(rdat);
    exp_q.push_back(exp);
    what_q.push_back(what);
  endtask

  task automatic reg_write(input logic [15:0] adr, input logic [1:0] sel,
                           input logic [15:0] wdat);
    logic [15:0] unused;
    bus_xfer(1'b1, sel, adr, wdat, 1, unused);
  endtask

  task automatic send_frame(input int p, input int n, input bit keep);
    logic [7:0] b;
    if (keep) begin
      sent_len[p] = n;
    end
    for (int i = 0; i < n; i++) begin
      b = 8'($urandom);
      if (keep) begin
        sent[p][i] = b;
      end
      @(posedge clk_125);
      #1;
      rx_dv[p] = 1'b1;
      rxd[p]   = b;
    end
    @(posedge clk_125);
    #1;
    rx_dv[p] = 1'b0;
    rxd[p]   = '0;
  endtask

  // poll status until every bit of the mask is set
  task automatic wait_ready(input logic [`NUM_PORTS-1:0] mask);
    logic [15:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while ((st[`NUM_PORTS-1:0] & mask) != mask && polls < POLL_LIMIT) begin
      bus_xfer(1'b0, 2'b11, reg_addr(`REG_STATUS), '0, 1, st);
      polls++;
    end
    if ((st[`NUM_PORTS-1:0] & mask) != mask) begin
      timeout_count++;
      $display("timeout: ready bits %b never set at time %0t", mask, $time);
    end
  endtask

  task automatic check_irq(input logic exp);
    @(negedge clk_125);
    assert (irq === exp) else begin
      error_count++;
      $display("[FAIL] t=%0t irq_o is %b, expected %b", $time, irq, exp);
    end
  endtask

  task automatic check_slot(input int p);
    string tag;
    tag = $sformatf("port %0d", p);
    read_expect(meta_addr(p, `META_LEN), bus_lanes(expected_len(p)), 1, {tag, " length"});
    read_expect(meta_addr(p, `META_TS3), bus_lanes(CNT3_PAT), 1, {tag, " ts quarter 3"});
    read_expect(meta_addr(p, `META_TS2), bus_lanes(CNT2_PAT), 1, {tag, " ts quarter 2"});
    for (int w = 0; w < (sent_len[p] + 3) / 4; w++) begin
      for (int h = 0; h < 2; h++) begin
        read_expect(mem_addr(p, w, h), bus_lanes(expected_half(p, w, h)), 3,
                    $sformatf("%s word %0d half %0d", tag, w, h));
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // compare process
  // ----------------------------------------------------------------------
  always @(posedge clk_125) begin : compare_reads
    logic [15:0] got_v;
    logic [15:0] exp_v;
    string       what_v;
    while (got_q.size() != 0) begin
      got_v  = got_q.pop_front();
      exp_v  = exp_q.pop_front();
      what_v = what_q.pop_front();
      check_count++;
      assert (got_v === exp_v) else begin
        mismatch_count++;
        $display("[FAIL] t=%0t %s read %h, expected %h", $time, what_v, got_v, exp_v);
      end
    end
  end

  initial begin : stimulus
    int n;
    void'($urandom(32'ha68a_b8f9));
    bus_cyc        = 1'b0;
    bus_stb        = 1'b0;
    bus_we         = 1'b0;
    bus_sel        = '0;
    bus_adr        = '0;
    bus_wdat       = '0;
    rx_dv          = '0;
    rxd            = '0;
    sent_len[0]    = 0;
    sent_len[1]    = 0;
    check_count    = 0;
    mismatch_count = 0;
    error_count    = 0;
    timeout_count  = 0;

    for (int i = 0; i < 20 && !core_rst_n; i++) begin
      @(posedge clk_125);
    end
    if (!core_rst_n) begin
      timeout_count++;
      $display("timeout: reset was never released");
    end

    // idle state after reset
    read_expect(reg_addr(`REG_STATUS), 16'h0000, 1, "status after reset");
    check_irq(1'b0);
    read_expect(16'h2000, 16'h0000, 1, "unmapped region");
    read_expect(reg_addr(1), 16'h0000, 1, "unused global index");

    // one lane per write, junk on the disabled lane
    reg_write(reg_addr(`REG_CNT3), 2'b01, {CNT3_PAT[7:0], 8'h5a});
    reg_write(reg_addr(`REG_CNT3), 2'b10, {8'h77, CNT3_PAT[15:8]});
    reg_write(reg_addr(`REG_CNT2), 2'b11, bus_lanes(CNT2_PAT));
    read_expect(reg_addr(`REG_CNT3), bus_lanes(CNT3_PAT), 1, "counter quarter 3");
    read_expect(reg_addr(`REG_CNT2), bus_lanes(CNT2_PAT), 1, "counter quarter 2");

    n = 1 + int'($urandom % 200);
    send_frame(0, n, 1'b1);
    wait_ready(2'b01);
    read_expect(reg_addr(`REG_STATUS), 16'h0001, 1, "status after port 0 frame");
    check_irq(1'b1);
    check_slot(0);

    // port 0 is full, so this frame must leave the slot untouched
    send_frame(0, 1 + int'($urandom % 200), 1'b0);
    repeat (4) @(posedge clk_125);
    read_expect(reg_addr(`REG_STATUS), 16'h0001, 1, "status after ignored frame");
    check_slot(0);

    send_frame(1, 1 + int'($urandom % 200), 1'b1);
    wait_ready(2'b10);
    read_expect(reg_addr(`REG_STATUS), 16'h0003, 1, "status with both ports full");
    check_slot(1);

    // status byte only counts with sel[1]
    reg_write(reg_addr(`REG_STATUS), 2'b01, 16'h0000);
    read_expect(reg_addr(`REG_STATUS), 16'h0003, 1, "status after sel[0] write");
    reg_write(reg_addr(`REG_STATUS), 2'b10, 16'h0002);
    read_expect(reg_addr(`REG_STATUS), 16'h0002, 1, "status after port 0 release");
    check_irq(1'b1);

    send_frame(0, 1 + int'($urandom % 200), 1'b1);
    wait_ready(2'b01);
    read_expect(reg_addr(`REG_STATUS), 16'h0003, 1, "status after new port 0 frame");
    check_slot(0);
    check_slot(1);

    reg_write(reg_addr(`REG_STATUS), 2'b10, 16'h0000);
    read_expect(reg_addr(`REG_STATUS), 16'h0000, 1, "status after full release");
    check_irq(1'b0);

    repeat (3) @(posedge clk_125);
    $display("reads compared %0d, mismatches %0d, other errors %0d, timeouts %0d",
             check_count, mismatch_count, error_count, timeout_count);
    if (mismatch_count + error_count + timeout_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`default_nettype none

module clock_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release just after an edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/nic_rx_top.sv
`default_nettype none

`include "nic_settings.svh"

module nic_rx_top (
  input  wire logic                        clk_125,
  input  wire logic                        core_rst_n,

  // host bus
  input  wire logic                        bus_cyc_i,
  input  wire logic                        bus_stb_i,
  input  wire logic                        bus_we_i,
  input  wire logic [1:0]                  bus_sel_i,
  input  wire logic [15:0]                 bus_adr_i,
  input  wire logic [`BUS_DW-1:0]          bus_dat_i,
  output logic      [`BUS_DW-1:0]          bus_dat_o,
  output logic                             bus_ack_o,

  // GMII receive, one lane per port
  input  wire logic [`NUM_PORTS-1:0]       gmii_rx_dv_i,
  input  wire logic [`NUM_PORTS-1:0][7:0]  gmii_rxd_i,

  output logic                             irq_o
);

  counter_wr_if cnt_bus ();
  slot_if       slot_bus [`NUM_PORTS] ();

  timestamp_counter u_counter (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .cnt        (cnt_bus.counter)
  );

  // ----------------------------------------------------------------------
  // receive ports
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
    rx_slot_port u_port (
      .clk_125      (clk_125),
      .core_rst_n   (core_rst_n),
      .gmii_rx_dv_i (gmii_rx_dv_i[p]),
      .gmii_rxd_i   (gmii_rxd_i[p]),
      .ts_i         (cnt_bus.value),
      .slot         (slot_bus[p].port)
    );
  end

  host_regs u_host (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .bus_cyc_i  (bus_cyc_i),
    .bus_stb_i  (bus_stb_i),
    .bus_we_i   (bus_we_i),
    .bus_sel_i  (bus_sel_i),
    .bus_adr_i  (bus_adr_i),
    .bus_dat_i  (bus_dat_i),
    .bus_dat_o  (bus_dat_o),
    .bus_ack_o  (bus_ack_o),
    .irq_o      (irq_o),
    .cnt        (cnt_bus.host),
    .slots      (slot_bus)
  );

endmodule

`default_nettype wire

//--- logic/host_regs.sv
`default_nettype none

`include "nic_settings.svh"

module host_regs (
  input  wire logic               clk_125,
  input  wire logic               core_rst_n,
  input  wire logic               bus_cyc_i,
  input  wire logic               bus_stb_i,
  input  wire logic               bus_we_i,
  input  wire logic [1:0]         bus_sel_i,
  input  wire logic [15:0]        bus_adr_i,
  input  wire logic [`BUS_DW-1:0] bus_dat_i,
  output logic      [`BUS_DW-1:0] bus_dat_o,
  output logic                    bus_ack_o,
  output logic                    irq_o,
  counter_wr_if.host              cnt,
  slot_if.host                    slots [`NUM_PORTS]
);

  localparam int PW = $clog2(`NUM_PORTS);
  localparam int AW = $clog2(`SLOT_WORDS);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_RAM  = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  nic_pkg::bus_addr_u    adr;
  logic [`NUM_PORTS-1:0] ready_vec;
  logic [`NUM_PORTS-1:0] rel_vec;
  logic [31:0]           rd_data_arr [`NUM_PORTS];
  nic_pkg::ts_t          ts_arr [`NUM_PORTS];
  nic_pkg::flen_t        len_arr [`NUM_PORTS];

  logic [2:0]            port_off;
  logic                  port_hit;
  logic [PW-1:0]         port_idx;
  logic                  is_global;
  logic                  is_meta;
  logic                  is_mem;
  logic                  req_new;
  logic                  status_wr;
  logic [15:0]           wr_val;
  logic [15:0]           rd_val;
  logic [15:0]           mem_half;

  logic [1:0]            state_q;
  logic                  ack_q;
  logic [15:0]           dat_q;
  logic [AW-1:0]         rd_addr_q;
  logic                  half_q;
  logic [PW-1:0]         port_q;

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_slot
    assign ready_vec[p]         = slots[p].ready;
    assign rd_data_arr[p]       = slots[p].rd_data;
    assign ts_arr[p]            = slots[p].timestamp;
    assign len_arr[p]           = slots[p].frame_len;
    assign slots[p].rd_addr     = rd_addr_q;
    assign slots[p].release_req = rel_vec[p];
  end

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  assign adr      = bus_adr_i;
  assign port_off = adr.meta.region - 3'(`REGION_PORT0);
  assign port_hit = (adr.meta.region >= 3'(`REGION_PORT0)) && (port_off < 3'(`NUM_PORTS));
  assign port_idx = port_off[PW-1:0];

  assign is_global = (adr.meta.region == 3'(`REGION_GLOBAL)) && !adr.meta.mem_sel &&
                     (adr.meta.pad == '0);
  assign is_meta   = port_hit && !adr.meta.mem_sel && (adr.meta.pad == '0);
  assign is_mem    = port_hit && adr.mem.mem_sel && !adr.mem.pad;

  assign req_new = bus_cyc_i && bus_stb_i && !ack_q && (state_q == ST_IDLE);

  // lanes are swapped, dat[15:8] carries the lower target byte
  assign wr_val = {bus_dat_i[7:0], bus_dat_i[15:8]};

  always_comb begin
    rd_val = '0;
    if (is_global) begin
      case (adr.meta.idx)
        // ready bits live in the upper byte, so bus bit p
        3'(`REG_STATUS): rd_val[15:8] = 8'(ready_vec);
        3'(`REG_CNT0):   rd_val = cnt.value[15:0];
        3'(`REG_CNT1):   rd_val = cnt.value[31:16];
        3'(`REG_CNT2):   rd_val = cnt.value[47:32];
        3'(`REG_CNT3):   rd_val = cnt.value[63:48];
        default:         rd_val = '0;
      endcase
    end else if (is_meta) begin
      case (adr.meta.idx)
        3'(`META_TS0): rd_val = ts_arr[port_idx][15:0];
        3'(`META_TS1): rd_val = ts_arr[port_idx][31:16];
        3'(`META_TS2): rd_val = ts_arr[port_idx][47:32];
        3'(`META_TS3): rd_val = ts_arr[port_idx][63:48];
        3'(`META_LEN): rd_val = 16'(len_arr[port_idx]);
        default:       rd_val = '0;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // writes: counter quarters and slot release
  // ----------------------------------------------------------------------
  assign cnt.wr_en   = req_new && bus_we_i && is_global &&
                       (adr.meta.idx >= 3'(`REG_CNT0)) && (adr.meta.idx <= 3'(`REG_CNT3));
  assign cnt.wr_idx  = 2'(adr.meta.idx - 3'(`REG_CNT0));
  assign cnt.wr_be   = bus_sel_i;
  assign cnt.wr_data = wr_val;

  assign status_wr = req_new && bus_we_i && is_global &&
                     (adr.meta.idx == 3'(`REG_STATUS)) && bus_sel_i[1];
  // writing 0 over a set ready bit frees that slot
  assign rel_vec   = status_wr ? (ready_vec & ~wr_val[8 +: `NUM_PORTS]) : '0;

  // ----------------------------------------------------------------------
  // ack and slot memory read sequence
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state_q <= ST_IDLE;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_new) begin
            if (is_mem && !bus_we_i) begin
              state_q <= ST_RAM;
            end else begin
              ack_q <= 1'b1;
            end
          end
        end
        ST_RAM:  state_q <= ST_DATA;
        ST_DATA: begin
          state_q <= ST_IDLE;
          ack_q   <= 1'b1;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign mem_half = half_q ? rd_data_arr[port_q][31:16] : rd_data_arr[port_q][15:0];

  always_ff @(posedge clk_125) begin
    if (req_new) begin
      rd_addr_q <= adr.mem.word;
      half_q    <= adr.mem.half;
      port_q    <= port_idx;
      dat_q     <= {rd_val[7:0], rd_val[15:8]};
    end
    if (state_q == ST_DATA) begin
      dat_q <= {mem_half[7:0], mem_half[15:8]};
    end
  end

  assign bus_dat_o = dat_q;
  assign bus_ack_o = ack_q;
  assign irq_o     = |ready_vec;

  a_ack_single: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    bus_ack_o |=> !bus_ack_o);

  a_stb_in_cyc: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    bus_stb_i |-> bus_cyc_i);

endmodule

`default_nettype wire

//--- logic/rx_slot_port.sv
`default_nettype none

`include "nic_settings.svh"

module rx_slot_port (
  input wire logic         clk_125,
  input wire logic         core_rst_n,
  input wire logic         gmii_rx_dv_i,
  input wire logic [7:0]   gmii_rxd_i,
  input wire nic_pkg::ts_t ts_i,
  slot_if.port             slot
);

  localparam int AW = $clog2(`SLOT_WORDS);
  localparam nic_pkg::flen_t LEN_MAX = nic_pkg::flen_t'(`SLOT_WORDS * 4 - 1);

  logic [31:0]    mem [`SLOT_WORDS];
  logic [31:0]    rd_data_q;

  logic           dv_q;
  logic           in_frame;
  logic           full_q;
  logic           ready_q;
  logic [1:0]     lane_q;
  logic [AW-1:0]  wr_ptr_q;
  nic_pkg::flen_t len_cnt_q;

  logic [31:0]    word_q;
  logic [31:0]    word_nxt;
  logic [31:0]    mem_wdata;
  nic_pkg::ts_t   ts_q;
  nic_pkg::flen_t frame_len_q;

  logic           sof;
  logic           eof;
  logic           take;
  logic           mem_we;

  assign sof  = gmii_rx_dv_i && !dv_q;
  assign eof  = !gmii_rx_dv_i && dv_q;
  // a new frame only starts into an empty slot
  assign take = gmii_rx_dv_i && (sof ? !ready_q : in_frame) && !full_q;

  // ----------------------------------------------------------------------
  // byte packing, little endian
  // ----------------------------------------------------------------------
  always_comb begin
    word_nxt = (lane_q == 2'd0) ? '0 : word_q;
    word_nxt[lane_q*8 +: 8] = gmii_rxd_i;
  end

  // full word, or the partial word left at frame end
  assign mem_we    = (take && lane_q == 2'd3) || (eof && in_frame && lane_q != 2'd0);
  assign mem_wdata = take ? word_nxt : word_q;

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      dv_q      <= 1'b0;
      in_frame  <= 1'b0;
      full_q    <= 1'b0;
      ready_q   <= 1'b0;
      lane_q    <= '0;
      wr_ptr_q  <= '0;
      len_cnt_q <= '0;
    end else begin
      dv_q <= gmii_rx_dv_i;

      if (sof && !ready_q) begin
        in_frame <= 1'b1;
      end else if (eof) begin
        in_frame <= 1'b0;
      end

      if (take) begin
        lane_q <= lane_q + 1'b1;
        if (lane_q == 2'd3) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
          // last word of the slot written
          if (wr_ptr_q == '1) begin
            full_q <= 1'b1;
          end
        end
        if (len_cnt_q != LEN_MAX) begin
          len_cnt_q <= len_cnt_q + 1'b1;
        end
      end

      if (eof) begin
        lane_q    <= '0;
        wr_ptr_q  <= '0;
        full_q    <= 1'b0;
        len_cnt_q <= '0;
      end

      if (eof && in_frame) begin
        ready_q <= 1'b1;
      end else if (slot.release_req) begin
        ready_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_125) begin
    if (take) begin
      word_q <= word_nxt;
    end
    if (sof && !ready_q) begin
      ts_q <= ts_i;
    end
    if (eof && in_frame) begin
      frame_len_q <= len_cnt_q;
    end
  end

  // slot RAM, one write and one registered read port
  always_ff @(posedge clk_125) begin
    if (mem_we) begin
      mem[wr_ptr_q] <= mem_wdata;
    end
    rd_data_q <= mem[slot.rd_addr];
  end

  assign slot.rd_data   = rd_data_q;
  assign slot.timestamp = ts_q;
  assign slot.frame_len = frame_len_q;
  assign slot.ready     = ready_q;

  a_release_when_ready: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    slot.release_req |-> ready_q);

  a_lane_at_sof: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    sof |-> lane_q == 2'd0);

endmodule

`default_nettype wire

//--- logic/timestamp_counter.sv
`default_nettype none

`include "nic_settings.svh"

module timestamp_counter (
  input wire logic      clk_125,
  input wire logic      core_rst_n,
  counter_wr_if.counter cnt
);

  nic_pkg::ts_t count_q;
  nic_pkg::ts_t count_nxt;

  // increment first, then host bytes override their lanes
  always_comb begin
    count_nxt = count_q + 1'b1;
    if (cnt.wr_en) begin
      for (int b = 0; b < 2; b++) begin
        if (cnt.wr_be[b]) begin
          count_nxt[cnt.wr_idx*16 + b*8 +: 8] = cnt.wr_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_nxt;
    end
  end

  assign cnt.value = count_q;

endmodule

`default_nettype wire

//--- logic/nic_ifs.sv
`default_nettype none

`include "nic_settings.svh"

// one receive slot as seen from the host side
interface slot_if;
  logic [$clog2(`SLOT_WORDS)-1:0] rd_addr;
  logic [31:0]                    rd_data;
  nic_pkg::ts_t                   timestamp;
  nic_pkg::flen_t                 frame_len;
  logic                           ready;
  logic                           release_req;

  modport port (input rd_addr, release_req,
                output rd_data, timestamp, frame_len, ready);
  modport host (output rd_addr, release_req,
                input rd_data, timestamp, frame_len, ready);
endinterface

// timestamp value plus host byte writes
interface counter_wr_if;
  nic_pkg::ts_t value;
  logic         wr_en;
  logic [1:0]   wr_idx;
  logic [1:0]   wr_be;
  logic [15:0]  wr_data;

  modport counter (output value, input wr_en, wr_idx, wr_be, wr_data);
  modport host (input value, output wr_en, wr_idx, wr_be, wr_data);
endinterface

`default_nettype wire

//--- logic/nic_pkg.sv
`default_nettype none

`include "nic_settings.svh"

package nic_pkg;

  typedef logic [`TS_W-1:0]        ts_t;
  typedef logic [`FRAME_LEN_W-1:0] flen_t;

  // ----------------------------------------------------------------------
  // bus byte address, two decodes of the same word
  // ----------------------------------------------------------------------

  // registers: global block or port metadata
  typedef struct packed {
    logic [2:0] region;
    logic       mem_sel;
    logic [7:0] pad;
    logic [2:0] idx;
    logic       lsb;
  } meta_addr_s;

  // slot memory, one 32-bit word read as two halves
  typedef struct packed {
    logic [2:0] region;
    logic       mem_sel;
    logic       pad;
    logic [8:0] word;
    logic       half;
    logic       lsb;
  } mem_addr_s;

  typedef union packed {
    meta_addr_s meta;
    mem_addr_s  mem;
  } bus_addr_u;

endpackage

`default_nettype wire

//--- include/nic_settings.svh
`ifndef NIC_SETTINGS_SVH
`define NIC_SETTINGS_SVH

// port count and slot geometry
`define NUM_PORTS     2
`define SLOT_WORDS    512
`define FRAME_LEN_W   12
`define TS_W          64
`define BUS_DW        16

// address map regions
`define REGION_GLOBAL 0
`define REGION_PORT0  4

// global register indices
`define REG_STATUS    0
`define REG_CNT0      2
`define REG_CNT1      3
`define REG_CNT2      4
`define REG_CNT3      5

// per-port metadata indices
`define META_TS0      0
`define META_TS1      1
`define META_TS2      2
`define META_TS3      3
`define META_LEN      6

`endif
